// ==== rtl/channel_constants.sv ====
// Per-channel gain and offset table with valid bits, replayed as register writes on start
module channel_constants (
    input  logic                       core_clock,
    input  logic                       rst_n,
    input  logic                       config_valid,
    input  complex_pkg::const_config_t config_data,
    input  logic                       start,
    output logic                       const_valid,
    output complex_pkg::reg_write_t    const_write,
    output logic                       const_last,
    output logic                       has_constants
);
    import complex_pkg::*;

    localparam int N_ENTRIES   = N_CHANNELS * N_CONSTANTS;
    localparam int ENTRY_WIDTH = $clog2(N_ENTRIES);

    logic [DATA_WIDTH-1:0]    entry_value [N_ENTRIES];
    logic [N_ENTRIES-1:0]     entry_valid;
    logic [N_ENTRIES-1:0]     pending;
    logic [ENTRY_WIDTH-1:0]   config_index;
    logic [ENTRY_WIDTH-1:0]   replay_index;
    logic [CHANNEL_WIDTH-1:0] replay_channel;
    logic                     replay_is_offset;

    // Table index is the channel followed by the gain/offset select
    assign config_index = {config_data.channel, config_data.is_offset};
    assign {replay_channel, replay_is_offset} = replay_index;

    // Lowest pending entry goes out first, giving ascending table order
    always_comb begin
        replay_index = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                replay_index = ENTRY_WIDTH'(i);
            end
        end
    end

    always_comb begin
        const_valid      = |pending;
        const_write.addr = {replay_channel, replay_is_offset ? SLOT_OFFSET : SLOT_GAIN};
        const_write.data = entry_value[replay_index];
        // Last write when only one pending bit remains
        const_last       = const_valid && ((pending & (pending - 1'b1)) == '0);
    end

    assign has_constants = |entry_valid;

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            entry_valid <= '0;
            pending     <= '0;
            for (int i = 0; i < N_ENTRIES; i++) begin
                entry_value[i] <= '0;
            end
        end else begin
            if (config_valid) begin
                entry_value[config_index] <= config_data.value;
                entry_valid[config_index] <= 1'b1;
            end
            if (start) begin
                pending <= entry_valid;
            end else if (const_valid) begin
                pending[replay_index] <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/complex_pkg.sv ====
// Data sizes, register map slots and the packed structs carried on the strobes
package complex_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int N_CHANNELS     = 4;
    localparam int CHANNEL_WIDTH  = 2;
    localparam int SLOT_WIDTH     = 2;
    localparam int REG_ADDR_WIDTH = CHANNEL_WIDTH + SLOT_WIDTH;
    localparam int N_CONSTANTS    = 2;
    localparam int SETTLE_CYCLES  = 4;
    localparam int FIFO_DEPTH     = 4;

    // Each channel owns four consecutive words of the register memory
    localparam logic [SLOT_WIDTH-1:0] SLOT_INPUT  = 2'd0;
    localparam logic [SLOT_WIDTH-1:0] SLOT_GAIN   = 2'd1;
    localparam logic [SLOT_WIDTH-1:0] SLOT_OFFSET = 2'd2;
    localparam logic [SLOT_WIDTH-1:0] SLOT_RESULT = 2'd3;

    // Address is the channel index followed by the slot index
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     data;
    } reg_write_t;

    typedef struct packed {
        logic [CHANNEL_WIDTH-1:0] channel;
        logic                     is_offset;
        logic [DATA_WIDTH-1:0]    value;
    } const_config_t;

    typedef struct packed {
        logic [CHANNEL_WIDTH-1:0] channel;
        logic [DATA_WIDTH-1:0]    data;
    } result_t;

endpackage

// ==== rtl/core_complex.sv ====
// Compute complex top level with the start sequencer and all block instances
module core_complex (
    input  logic                       core_clock,
    input  logic                       rst_n,
    input  logic                       config_valid,
    input  complex_pkg::const_config_t config_data,
    input  logic                       dma_valid,
    input  complex_pkg::reg_write_t    dma_write,
    input  logic                       start,
    output logic                       out_valid,
    output complex_pkg::result_t       out_data,
    output logic                       done
);
    import complex_pkg::*;

    localparam int SETTLE_WIDTH = $clog2(SETTLE_CYCLES + 1);

    logic                      const_valid;
    reg_write_t                const_write;
    logic                      const_last;
    logic                      has_constants;
    logic                      merged_valid;
    reg_write_t                merged_write;
    logic                      run;
    logic                      core_done;
    logic [REG_ADDR_WIDTH-1:0] read_addr;
    logic [DATA_WIDTH-1:0]     read_data;
    logic [SETTLE_WIDTH-1:0]   settle_count;

    channel_constants constants_i (
        .core_clock    (core_clock),
        .rst_n         (rst_n),
        .config_valid  (config_valid),
        .config_data   (config_data),
        .start         (start),
        .const_valid   (const_valid),
        .const_write   (const_write),
        .const_last    (const_last),
        .has_constants (has_constants)
    );

    write_combiner #(
        .payload_t (reg_write_t)
    ) combiner_i (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .a_valid    (const_valid),
        .a_data     (const_write),
        .b_valid    (dma_valid),
        .b_data     (dma_write),
        .out_valid  (merged_valid),
        .out_data   (merged_write)
    );

    // Run waits for the merged path to settle after the last replayed constant
    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            settle_count <= '0;
            run          <= 1'b0;
        end else begin
            run <= 1'b0;
            // With an empty table there is nothing to replay
            if (start && !has_constants) begin
                run <= 1'b1;
            end
            if (const_last) begin
                settle_count <= SETTLE_WIDTH'(1);
            end else if (settle_count == SETTLE_WIDTH'(SETTLE_CYCLES - 1)) begin
                settle_count <= '0;
                run          <= 1'b1;
            end else if (settle_count != '0) begin
                settle_count <= settle_count + 1'b1;
            end
        end
    end

    kernel_core core_i (
        .core_clock  (core_clock),
        .rst_n       (rst_n),
        .write_valid (merged_valid),
        .write       (merged_write),
        .run         (run),
        .done        (core_done),
        .read_addr   (read_addr),
        .read_data   (read_data)
    );

    result_mover mover_i (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .start      (core_done),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .done       (done)
    );

endmodule

// ==== rtl/kernel_core.sv ====
// Register memory, per-channel multiply-add sequence and registered result read port
module kernel_core (
    input  logic                                   core_clock,
    input  logic                                   rst_n,
    input  logic                                   write_valid,
    input  complex_pkg::reg_write_t                write,
    input  logic                                   run,
    output logic                                   done,
    input  logic [complex_pkg::REG_ADDR_WIDTH-1:0] read_addr,
    output logic [complex_pkg::DATA_WIDTH-1:0]     read_data
);
    import complex_pkg::*;

    localparam int N_REGS = 2 ** REG_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0]    reg_mem [N_REGS];
    logic                     busy;
    logic [CHANNEL_WIDTH-1:0] channel;
    logic [DATA_WIDTH-1:0]    in_word;
    logic [DATA_WIDTH-1:0]    gain_word;
    logic [DATA_WIDTH-1:0]    offset_word;
    logic [DATA_WIDTH-1:0]    result_word;

    assign in_word     = reg_mem[{channel, SLOT_INPUT}];
    assign gain_word   = reg_mem[{channel, SLOT_GAIN}];
    assign offset_word = reg_mem[{channel, SLOT_OFFSET}];

    // Evaluated at data width, so only the low word of the sum survives
    assign result_word = in_word * gain_word + offset_word;

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            channel <= '0;
            done    <= 1'b0;
            for (int i = 0; i < N_REGS; i++) begin
                reg_mem[i] <= '0;
            end
        end else begin
            done <= 1'b0;
            if (write_valid) begin
                reg_mem[write.addr] <= write.data;
            end
            if (run) begin
                busy    <= 1'b1;
                channel <= '0;
            end else if (busy) begin
                // One channel per cycle, result lands in the channel's own slot
                reg_mem[{channel, SLOT_RESULT}] <= result_word;
                channel <= channel + 1'b1;
                if (channel == CHANNEL_WIDTH'(N_CHANNELS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clock) begin
        read_data <= reg_mem[read_addr];
    end

endmodule

// ==== rtl/result_mover.sv ====
// FSM that reads every result slot after the core finishes and streams the results out
module result_mover (
    input  logic                                   core_clock,
    input  logic                                   rst_n,
    input  logic                                   start,
    output logic [complex_pkg::REG_ADDR_WIDTH-1:0] read_addr,
    input  logic [complex_pkg::DATA_WIDTH-1:0]     read_data,
    output logic                                   out_valid,
    output complex_pkg::result_t                   out_data,
    output logic                                   done
);
    import complex_pkg::*;

    typedef enum logic {
        IDLE,
        READ
    } state_t;

    state_t                   state;
    logic [CHANNEL_WIDTH-1:0] read_channel;
    logic [CHANNEL_WIDTH-1:0] resp_channel;

    assign read_addr = {read_channel, SLOT_RESULT};

    // Read data returns one cycle after the address, tagged with the channel it came from
    assign out_data.channel = resp_channel;
    assign out_data.data    = read_data;
    assign done             = out_valid && resp_channel == CHANNEL_WIDTH'(N_CHANNELS - 1);

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            state        <= IDLE;
            read_channel <= '0;
            resp_channel <= '0;
            out_valid    <= 1'b0;
        end else begin
            out_valid    <= state == READ;
            resp_channel <= read_channel;
            case (state)
                IDLE: begin
                    if (start) begin
                        state        <= READ;
                        read_channel <= '0;
                    end
                end
                READ: begin
                    read_channel <= read_channel + 1'b1;
                    if (read_channel == CHANNEL_WIDTH'(N_CHANNELS - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/write_combiner.sv ====
// Two-input write merger with priority on input a and a small FIFO for input b
module write_combiner #(
    parameter type payload_t = logic
) (
    input  logic     core_clock,
    input  logic     rst_n,
    input  logic     a_valid,
    input  payload_t a_data,
    input  logic     b_valid,
    input  payload_t b_data,
    output logic     out_valid,
    output payload_t out_data
);
    import complex_pkg::*;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    payload_t             buffer [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 fifo_empty;
    logic                 fifo_full;
    logic                 pop;
    logic                 push;
    logic                 b_direct;

    assign fifo_empty = count == '0;
    assign fifo_full  = count == (PTR_WIDTH + 1)'(FIFO_DEPTH);

    // The FIFO drains only while input a is idle
    assign pop      = !a_valid && !fifo_empty;
    // b bypasses the FIFO only when nothing older is waiting
    assign b_direct = b_valid && !a_valid && fifo_empty;
    // A write arriving on a full FIFO is lost
    assign push     = b_valid && !b_direct && (!fifo_full || pop);

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= a_valid || pop || b_direct;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge core_clock) begin
        if (push) begin
            buffer[wr_ptr] <= b_data;
        end
        if (a_valid) begin
            out_data <= a_data;
        end else if (pop) begin
            out_data <= buffer[rd_ptr];
        end else begin
            out_data <= b_data;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module core_complex_tb -f src.f -o sim_core_complex

./obj_dir/sim_core_complex > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

// ==== sim/complex_checker.sv ====
// Reference model of the register memory, expected-result function and output comparison
module complex_checker (
    input  logic                       core_clock,
    input  logic                       rst_n,
    input  logic                       config_valid,
    input  complex_pkg::const_config_t config_data,
    input  logic                       dma_valid,
    input  complex_pkg::reg_write_t    dma_write,
    input  logic                       start,
    input  logic                       out_valid,
    input  complex_pkg::result_t       out_data,
    input  logic                       done,
    output int                         error_count,
    output int                         done_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import complex_pkg::*;

    localparam int N_ENTRIES = N_CHANNELS * N_CONSTANTS;

    logic [DATA_WIDTH-1:0] table_value [N_ENTRIES];
    logic [N_ENTRIES-1:0]  table_valid;
    logic [DATA_WIDTH-1:0] model_mem [2 ** REG_ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] expected [N_CHANNELS];
    int                    out_index;
    int                    new_errors;

    // Product and sum taken at double width, then reduced modulo 2^32
    function automatic logic [DATA_WIDTH-1:0] expected_result(
        input logic [DATA_WIDTH-1:0] in_word,
        input logic [DATA_WIDTH-1:0] gain,
        input logic [DATA_WIDTH-1:0] offset
    );
        logic [2*DATA_WIDTH-1:0] full;
        full = 64'(in_word) * 64'(gain) + 64'(offset);
        return full[DATA_WIDTH-1:0];
    endfunction

    // Entry e holds channel e/2, with the low bit choosing gain or offset
    task automatic replay_table();
        logic [CHANNEL_WIDTH-1:0] ch;
        for (int e = 0; e < N_ENTRIES; e++) begin
            ch = CHANNEL_WIDTH'(e / 2);
            if (table_valid[e]) begin
                model_mem[{ch, (e % 2 == 1) ? SLOT_OFFSET : SLOT_GAIN}] = table_value[e];
            end
        end
    endtask

    initial begin
        error_count = 0;
        done_count  = 0;
    end

    always @(posedge core_clock) begin
        new_errors = 0;
        if (!rst_n) begin
            table_valid = '0;
            out_index   = 0;
            for (int i = 0; i < N_ENTRIES; i++) begin
                table_value[i] = '0;
            end
            for (int i = 0; i < 2 ** REG_ADDR_WIDTH; i++) begin
                model_mem[i] = '0;
            end
        end else begin
            // DMA goes straight through on the start cycle, so the replay lands after it
            if (dma_valid) begin
                model_mem[dma_write.addr] = dma_write.data;
            end
            if (start) begin
                replay_table();
            end
            if (config_valid) begin
                table_value[{config_data.channel, config_data.is_offset}] = config_data.value;
                table_valid[{config_data.channel, config_data.is_offset}] = 1'b1;
            end
            if (out_valid) begin
                if (out_index == 0) begin
                    for (int c = 0; c < N_CHANNELS; c++) begin
                        expected[c] = expected_result(
                            model_mem[{CHANNEL_WIDTH'(c), SLOT_INPUT}],
                            model_mem[{CHANNEL_WIDTH'(c), SLOT_GAIN}],
                            model_mem[{CHANNEL_WIDTH'(c), SLOT_OFFSET}]);
                    end
                end
                if (out_data.channel != CHANNEL_WIDTH'(out_index)) begin
                    $display("[ERROR] out_data.channel: expected %h, actual %h",
                             CHANNEL_WIDTH'(out_index), out_data.channel);
                    new_errors++;
                end
                if (out_data.data != expected[out_index]) begin
                    $display("[ERROR] out_data.data channel %0d: expected %h, actual %h",
                             out_index, expected[out_index], out_data.data);
                    new_errors++;
                end
                if (out_index == N_CHANNELS - 1) begin
                    if (!done) begin
                        $display("done did not arrive with the fourth output");
                        new_errors++;
                    end
                    out_index = 0;
                end else begin
                    if (done) begin
                        $display("done arrived before the fourth output");
                        new_errors++;
                    end
                    out_index++;
                end
            end else if (done) begin
                $display("done pulsed without any output");
                new_errors++;
            end
            error_count <= error_count + new_errors;
            done_count  <= done_count + (done ? 1 : 0);
        end
    end

endmodule

// ==== sim/core_complex_properties.sv ====
// Concurrent assertions on strobe widths and run sequencing of the compute complex
module core_complex_properties (
    input logic core_clock,
    input logic rst_n,
    input logic start,
    input logic run,
    input logic out_valid,
    input logic done,
    input logic dma_valid,
    input logic config_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic active;

    // Active covers the cycles from run until the mover's done
    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (run) begin
            active <= 1'b1;
        end else if (done) begin
            active <= 1'b0;
        end
    end

    start_pulse: assert property (@(posedge core_clock) disable iff (!rst_n) start |=> !start)
        else $error("start held high for more than one cycle");
    run_pulse: assert property (@(posedge core_clock) disable iff (!rst_n) run |=> !run)
        else $error("run held high for more than one cycle");
    done_pulse: assert property (@(posedge core_clock) disable iff (!rst_n) done |=> !done)
        else $error("done held high for more than one cycle");
    output_after_run: assert property (@(posedge core_clock) disable iff (!rst_n)
        out_valid |-> active)
        else $error("out_valid seen outside a run");
    quiet_while_running: assert property (@(posedge core_clock) disable iff (!rst_n)
        (run || active) |-> !(dma_valid || config_valid))
        else $error("host write arrived between run and done");

endmodule

// ==== sim/core_complex_tb.sv ====
// Testbench top with clock, reset, LCG stimulus for each test, timeout and summary
module core_complex_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import complex_pkg::*;

    localparam int RESET_CYCLES = 8;
    // Five tests start the complex eight times in all
    localparam int N_STARTS     = 8;
    localparam int START_BUDGET = 60;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_STARTS * START_BUDGET;

    logic          core_clock;
    logic          rst_n;
    logic          config_valid;
    const_config_t config_data;
    logic          dma_valid;
    reg_write_t    dma_write;
    logic          start;
    logic          out_valid;
    result_t       out_data;
    logic          done;
    int            checker_errors;
    int            done_count;
    int            errors_before;
    int            dones_before;
    int            test_count;
    int            failed_tests;
    int            cycle_count;
    logic [31:0]   lcg_state;

    core_complex dut_i (
        .core_clock   (core_clock),
        .rst_n        (rst_n),
        .config_valid (config_valid),
        .config_data  (config_data),
        .dma_valid    (dma_valid),
        .dma_write    (dma_write),
        .start        (start),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .done         (done)
    );

    complex_checker checker_i (
        .core_clock   (core_clock),
        .rst_n        (rst_n),
        .config_valid (config_valid),
        .config_data  (config_data),
        .dma_valid    (dma_valid),
        .dma_write    (dma_write),
        .start        (start),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .done         (done),
        .error_count  (checker_errors),
        .done_count   (done_count)
    );

    bind core_complex core_complex_properties properties_i (
        .core_clock   (core_clock),
        .rst_n        (rst_n),
        .start        (start),
        .run          (run),
        .out_valid    (out_valid),
        .done         (done),
        .dma_valid    (dma_valid),
        .config_valid (config_valid)
    );

    always #2 core_clock = ~core_clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_word(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value     = lcg_state;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge core_clock);
    endtask

    task automatic send_config(input logic [1:0] channel, input logic is_offset,
                               input logic [31:0] value);
        config_valid <= 1'b1;
        config_data  <= {channel, is_offset, value};
        @(posedge core_clock);
        config_valid <= 1'b0;
    endtask

    task automatic send_input(input logic [1:0] channel, input logic [31:0] value);
        dma_valid <= 1'b1;
        dma_write <= {channel, SLOT_INPUT, value};
        @(posedge core_clock);
        dma_valid <= 1'b0;
    endtask

    task automatic load_random_constants();
        logic [31:0] gain;
        logic [31:0] offset;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            random_word(gain);
            random_word(offset);
            send_config(2'(ch), 1'b0, gain);
            send_config(2'(ch), 1'b1, offset);
        end
    endtask

    task automatic load_random_inputs();
        logic [31:0] value;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            random_word(value);
            send_input(2'(ch), value);
        end
    endtask

    task automatic wait_for_done();
        do begin
            @(posedge core_clock);
        end while (!done);
        // A few quiet cycles so a second done would still be counted
        idle(3);
    endtask

    task automatic start_and_wait();
        start <= 1'b1;
        @(posedge core_clock);
        start <= 1'b0;
        wait_for_done();
    endtask

    task automatic begin_test();
        errors_before = checker_errors;
        dones_before  = done_count;
    endtask

    task automatic end_test(input string name, input int starts);
        int errors;
        int dones;
        errors = checker_errors - errors_before;
        dones  = done_count - dones_before;
        test_count++;
        if (dones != starts) begin
            $display("test %0d %s: expected %0d done pulses but saw %0d",
                     test_count, name, starts, dones);
            errors++;
        end
        if (errors == 0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, errors);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge core_clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] value;
        core_clock   = 1'b0;
        rst_n        = 1'b0;
        config_valid = 1'b0;
        config_data  = '0;
        dma_valid    = 1'b0;
        dma_write    = '0;
        start        = 1'b0;
        lcg_state    = 32'h2102;
        test_count   = 0;
        failed_tests = 0;
        idle(RESET_CYCLES);
        rst_n <= 1'b1;
        idle(2);

        // Gains and offsets are still cleared, so every result is zero
        begin_test();
        load_random_inputs();
        idle(2);
        start_and_wait();
        end_test("empty table", 1);

        begin_test();
        load_random_constants();
        load_random_inputs();
        idle(2);
        start_and_wait();
        end_test("full config", 1);

        // These inputs queue in the combiner FIFO behind the replayed constants
        begin_test();
        start <= 1'b1;
        @(posedge core_clock);
        start <= 1'b0;
        for (int ch = 0; ch < 3; ch++) begin
            random_word(value);
            send_input(2'(ch), value);
        end
        wait_for_done();
        end_test("collision", 1);

        begin_test();
        random_word(value);
        send_config(2'd1, 1'b1, value);
        idle(1);
        start_and_wait();
        end_test("partial update", 1);

        begin_test();
        repeat (4) begin
            load_random_constants();
            load_random_inputs();
            idle(2);
            start_and_wait();
        end
        end_test("random runs", 4);

        $display("%0d tests, %0d failed, %0d checker errors",
                 test_count, failed_tests, checker_errors);
        if (failed_tests == 0 && checker_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/complex_pkg.sv
rtl/channel_constants.sv
rtl/write_combiner.sv
rtl/kernel_core.sv
rtl/result_mover.sv
rtl/core_complex.sv
sim/core_complex_properties.sv
sim/complex_checker.sv
sim/core_complex_tb.sv
